/* flist.f */
+incdir+test
src/lsu_pkg.sv
src/addr_gen.sv
src/lq_idx_alloc.sv
src/load_pipe.sv
src/store_pipe.sv
src/violation_detect.sv
src/lsu_top.sv
test/lsu_tb.sv

/* src/addr_gen.sv */
module addr_gen (
    input  logic [lsu_pkg::ADDR_W-1:0] base_i,
    input  logic [lsu_pkg::IMM_W-1:0]  imm_i,
    input  lsu_pkg::mem_size_e         size_i,
    output logic [lsu_pkg::ADDR_W-1:0] addr_o,
    output lsu_pkg::mask_t             mask_o
);

    logic [lsu_pkg::ADDR_W-1:0] imm_ext;

    assign imm_ext = {{(lsu_pkg::ADDR_W - lsu_pkg::IMM_W){imm_i[lsu_pkg::IMM_W-1]}}, imm_i};
    assign addr_o  = base_i + imm_ext;

    // byte lanes touched by the access
    always_comb begin
        case (size_i)
            lsu_pkg::SIZE_WORD: begin
                mask_o = 4'b1111;
            end
            lsu_pkg::SIZE_HALF: begin
                case (addr_o[1:0])
                    2'b00:   mask_o = 4'b0011;
                    2'b01:   mask_o = 4'b0110;
                    2'b10:   mask_o = 4'b1100;
                    default: mask_o = 4'b1000;
                endcase
            end
            default: begin
                mask_o = 4'b0001 << addr_o[1:0];
            end
        endcase
    end

endmodule

/* src/load_pipe.sv */
module load_pipe (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       load_valid_i,
    input  logic [lsu_pkg::ADDR_W-1:0] load_base_i,
    input  logic [lsu_pkg::IMM_W-1:0]  load_imm_i,
    input  lsu_pkg::mem_size_e         load_size_i,
    input  lsu_pkg::rob_idx_t          load_rob_i,
    input  lsu_pkg::lq_idx_t           load_lq_i,
    input  logic                       redirect_i,
    input  lsu_pkg::rob_idx_t          redirect_rob_i,
    output logic                       s1_valid_o,
    output logic [lsu_pkg::ADDR_W-1:0] s1_addr_o,
    output lsu_pkg::mask_t             s1_mask_o,
    output lsu_pkg::lq_idx_t           s1_lq_o,
    output lsu_pkg::rob_idx_t          s1_rob_o,
    output logic                       s2_valid_o,
    output logic [lsu_pkg::ADDR_W-1:0] s2_addr_o,
    output lsu_pkg::mask_t             s2_mask_o,
    output lsu_pkg::lq_idx_t           s2_lq_o,
    output lsu_pkg::rob_idx_t          s2_rob_o,
    output logic                       done_valid_o,
    output lsu_pkg::rob_idx_t          done_rob_o,
    output lsu_pkg::lq_idx_t           done_lq_o
);

    logic [lsu_pkg::ADDR_W-1:0] issue_addr;
    lsu_pkg::mask_t             issue_mask;
    logic                       kill_issue;
    logic                       kill_s1;
    logic                       kill_s2;

    addr_gen addr_gen_inst (
        .base_i (load_base_i),
        .imm_i  (load_imm_i),
        .size_i (load_size_i),
        .addr_o (issue_addr),
        .mask_o (issue_mask)
    );

    // a redirect flushes everything younger than the redirect point
    assign kill_issue = redirect_i && lsu_pkg::rob_older(redirect_rob_i, load_rob_i);
    assign kill_s1    = redirect_i && lsu_pkg::rob_older(redirect_rob_i, s1_rob_o);
    assign kill_s2    = redirect_i && lsu_pkg::rob_older(redirect_rob_i, s2_rob_o);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            s1_valid_o <= 1'b0;
            s2_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= load_valid_i && !kill_issue;
            s2_valid_o <= s1_valid_o && !kill_s1;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr_o <= issue_addr;
        s1_mask_o <= issue_mask;
        s1_lq_o   <= load_lq_i;
        s1_rob_o  <= load_rob_i;
        s2_addr_o <= s1_addr_o;
        s2_mask_o <= s1_mask_o;
        s2_lq_o   <= s1_lq_o;
        s2_rob_o  <= s1_rob_o;
    end

    // completion drops a load killed in its last stage
    assign done_valid_o = s2_valid_o && !kill_s2;
    assign done_rob_o   = s2_rob_o;
    assign done_lq_o    = s2_lq_o;

endmodule

/* src/lq_idx_alloc.sv */
module lq_idx_alloc (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             alloc_i,
    output lsu_pkg::lq_idx_t next_lq_o
);

    lsu_pkg::lq_idx_t next_lq;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            next_lq <= '0;
        end else if (alloc_i) begin
            next_lq.idx <= next_lq.idx + 1'b1;
            // flip the wrap bit as the slot index rolls over
            if (&next_lq.idx) begin
                next_lq.dir <= ~next_lq.dir;
            end
        end
    end

    assign next_lq_o = next_lq;

endmodule

/* src/lsu_pkg.sv */
package lsu_pkg;

    // architectural widths
    localparam int ADDR_W = 32;
    localparam int IMM_W  = 12;
    localparam int ROB_W  = 5;
    localparam int LQ_W   = 3;

    // one bit per byte of a 4-byte word
    typedef logic [3:0] mask_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // ring indices carry a wrap bit above the slot index
    typedef struct packed {
        logic             dir;
        logic [ROB_W-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic            dir;
        logic [LQ_W-1:0] idx;
    } lq_idx_t;

    // true when a is strictly older than b
    function automatic logic rob_older(rob_idx_t a, rob_idx_t b);
        if (a.dir == b.dir) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

    function automatic logic lq_older(lq_idx_t a, lq_idx_t b);
        if (a.dir == b.dir) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

endpackage

/* src/lsu_top.sv */
module lsu_top (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       load_valid_i,
    input  logic [lsu_pkg::ADDR_W-1:0] load_base_i,
    input  logic [lsu_pkg::IMM_W-1:0]  load_imm_i,
    input  lsu_pkg::mem_size_e         load_size_i,
    input  lsu_pkg::rob_idx_t          load_rob_i,
    input  logic                       store_valid_i,
    input  logic [lsu_pkg::ADDR_W-1:0] store_base_i,
    input  logic [lsu_pkg::IMM_W-1:0]  store_imm_i,
    input  lsu_pkg::mem_size_e         store_size_i,
    input  lsu_pkg::rob_idx_t          store_rob_i,
    input  logic                       redirect_i,
    input  lsu_pkg::rob_idx_t          redirect_rob_i,
    output logic                       load_req_valid_o,
    output logic [lsu_pkg::ADDR_W-1:0] load_req_addr_o,
    output lsu_pkg::mask_t             load_req_mask_o,
    output logic                       load_done_valid_o,
    output lsu_pkg::rob_idx_t          load_done_rob_o,
    output lsu_pkg::lq_idx_t           load_done_lq_o,
    output logic                       store_req_valid_o,
    output logic [lsu_pkg::ADDR_W-1:0] store_req_addr_o,
    output lsu_pkg::mask_t             store_req_mask_o,
    output lsu_pkg::rob_idx_t          store_req_rob_o,
    output logic                       violation_valid_o,
    output lsu_pkg::rob_idx_t          violation_rob_o
);

    lsu_pkg::lq_idx_t           next_lq;
    lsu_pkg::lq_idx_t           ld1_lq;
    lsu_pkg::rob_idx_t          ld1_rob;
    logic                       ld2_valid;
    logic [lsu_pkg::ADDR_W-1:0] ld2_addr;
    lsu_pkg::mask_t             ld2_mask;
    lsu_pkg::lq_idx_t           ld2_lq;
    lsu_pkg::rob_idx_t          ld2_rob;
    logic                       st1_valid;
    lsu_pkg::lq_idx_t           st1_lq;

    lq_idx_alloc lq_idx_alloc_inst (
        .clk       (clk),
        .rst_i     (rst_i),
        .alloc_i   (load_valid_i),
        .next_lq_o (next_lq)
    );

    load_pipe load_pipe_inst (
        .clk (clk), .rst_i (rst_i),
        .load_valid_i   (load_valid_i),
        .load_base_i    (load_base_i),
        .load_imm_i     (load_imm_i),
        .load_size_i    (load_size_i),
        .load_rob_i     (load_rob_i),
        .load_lq_i      (next_lq),
        .redirect_i     (redirect_i),
        .redirect_rob_i (redirect_rob_i),
        .s1_valid_o     (load_req_valid_o),
        .s1_addr_o      (load_req_addr_o),
        .s1_mask_o      (load_req_mask_o),
        .s1_lq_o        (ld1_lq),
        .s1_rob_o       (ld1_rob),
        .s2_valid_o     (ld2_valid),
        .s2_addr_o      (ld2_addr),
        .s2_mask_o      (ld2_mask),
        .s2_lq_o        (ld2_lq),
        .s2_rob_o       (ld2_rob),
        .done_valid_o   (load_done_valid_o),
        .done_rob_o     (load_done_rob_o),
        .done_lq_o      (load_done_lq_o)
    );

    // store sees the same next_lq a same-cycle load takes
    store_pipe store_pipe_inst (
        .clk (clk), .rst_i (rst_i),
        .store_valid_i  (store_valid_i),
        .store_base_i   (store_base_i),
        .store_imm_i    (store_imm_i),
        .store_size_i   (store_size_i),
        .store_rob_i    (store_rob_i),
        .store_lq_i     (next_lq),
        .redirect_i     (redirect_i),
        .redirect_rob_i (redirect_rob_i),
        .s1_valid_o     (st1_valid),
        .s1_addr_o      (store_req_addr_o),
        .s1_mask_o      (store_req_mask_o),
        .s1_lq_o        (st1_lq),
        .req_valid_o    (store_req_valid_o),
        .req_rob_o      (store_req_rob_o)
    );

    violation_detect violation_detect_inst (
        .clk (clk), .rst_i (rst_i),
        .store_valid_i     (st1_valid),
        .store_addr_i      (store_req_addr_o),
        .store_mask_i      (store_req_mask_o),
        .store_lq_i        (st1_lq),
        .ld1_valid_i       (load_req_valid_o),
        .ld1_addr_i        (load_req_addr_o),
        .ld1_mask_i        (load_req_mask_o),
        .ld1_lq_i          (ld1_lq),
        .ld1_rob_i         (ld1_rob),
        .ld2_valid_i       (ld2_valid),
        .ld2_addr_i        (ld2_addr),
        .ld2_mask_i        (ld2_mask),
        .ld2_lq_i          (ld2_lq),
        .ld2_rob_i         (ld2_rob),
        .redirect_i        (redirect_i),
        .redirect_rob_i    (redirect_rob_i),
        .violation_valid_o (violation_valid_o),
        .violation_rob_o   (violation_rob_o)
    );

endmodule

/* src/store_pipe.sv */
module store_pipe (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       store_valid_i,
    input  logic [lsu_pkg::ADDR_W-1:0] store_base_i,
    input  logic [lsu_pkg::IMM_W-1:0]  store_imm_i,
    input  lsu_pkg::mem_size_e         store_size_i,
    input  lsu_pkg::rob_idx_t          store_rob_i,
    input  lsu_pkg::lq_idx_t           store_lq_i,
    input  logic                       redirect_i,
    input  lsu_pkg::rob_idx_t          redirect_rob_i,
    output logic                       s1_valid_o,
    output logic [lsu_pkg::ADDR_W-1:0] s1_addr_o,
    output lsu_pkg::mask_t             s1_mask_o,
    output lsu_pkg::lq_idx_t           s1_lq_o,
    output logic                       req_valid_o,
    output lsu_pkg::rob_idx_t          req_rob_o
);

    logic [lsu_pkg::ADDR_W-1:0] issue_addr;
    lsu_pkg::mask_t             issue_mask;
    logic                       kill_issue;
    logic                       kill_s1;

    addr_gen addr_gen_inst (
        .base_i (store_base_i),
        .imm_i  (store_imm_i),
        .size_i (store_size_i),
        .addr_o (issue_addr),
        .mask_o (issue_mask)
    );

    assign kill_issue = redirect_i && lsu_pkg::rob_older(redirect_rob_i, store_rob_i);
    assign kill_s1    = redirect_i && lsu_pkg::rob_older(redirect_rob_i, req_rob_o);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= store_valid_i && !kill_issue;
        end
    end

    // lq index is the first load slot younger than this store
    always_ff @(posedge clk) begin
        s1_addr_o <= issue_addr;
        s1_mask_o <= issue_mask;
        s1_lq_o   <= store_lq_i;
        req_rob_o <= store_rob_i;
    end

    assign req_valid_o = s1_valid_o && !kill_s1;

endmodule

/* src/violation_detect.sv */
module violation_detect (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       store_valid_i,
    input  logic [lsu_pkg::ADDR_W-1:0] store_addr_i,
    input  lsu_pkg::mask_t             store_mask_i,
    input  lsu_pkg::lq_idx_t           store_lq_i,
    input  logic                       ld1_valid_i,
    input  logic [lsu_pkg::ADDR_W-1:0] ld1_addr_i,
    input  lsu_pkg::mask_t             ld1_mask_i,
    input  lsu_pkg::lq_idx_t           ld1_lq_i,
    input  lsu_pkg::rob_idx_t          ld1_rob_i,
    input  logic                       ld2_valid_i,
    input  logic [lsu_pkg::ADDR_W-1:0] ld2_addr_i,
    input  lsu_pkg::mask_t             ld2_mask_i,
    input  lsu_pkg::lq_idx_t           ld2_lq_i,
    input  lsu_pkg::rob_idx_t          ld2_rob_i,
    input  logic                       redirect_i,
    input  lsu_pkg::rob_idx_t          redirect_rob_i,
    output logic                       violation_valid_o,
    output lsu_pkg::rob_idx_t          violation_rob_o
);

    logic              ld1_hit;
    logic              ld2_hit;
    logic              pick_ld2;
    logic              vio_valid;
    lsu_pkg::rob_idx_t vio_rob;

    // same word, shared byte, and the load is not older than the store
    assign ld1_hit = store_valid_i && ld1_valid_i
                  && !lsu_pkg::lq_older(ld1_lq_i, store_lq_i)
                  && (store_addr_i[lsu_pkg::ADDR_W-1:2] == ld1_addr_i[lsu_pkg::ADDR_W-1:2])
                  && |(store_mask_i & ld1_mask_i);

    assign ld2_hit = store_valid_i && ld2_valid_i
                  && !lsu_pkg::lq_older(ld2_lq_i, store_lq_i)
                  && (store_addr_i[lsu_pkg::ADDR_W-1:2] == ld2_addr_i[lsu_pkg::ADDR_W-1:2])
                  && |(store_mask_i & ld2_mask_i);

    // oldest offender gets replayed
    assign pick_ld2 = ld2_hit && (!ld1_hit || lsu_pkg::lq_older(ld2_lq_i, ld1_lq_i));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            vio_valid <= 1'b0;
        end else begin
            vio_valid <= ld1_hit || ld2_hit;
        end
    end

    always_ff @(posedge clk) begin
        vio_rob <= pick_ld2 ? ld2_rob_i : ld1_rob_i;
    end

    // no report for a load already flushed by this redirect
    assign violation_valid_o = vio_valid
                            && !(redirect_i && lsu_pkg::rob_older(redirect_rob_i, vio_rob));
    assign violation_rob_o   = vio_rob;

endmodule

/* test/lsu_ref.svh */
`ifndef LSU_REF_SVH
`define LSU_REF_SVH

// with equal wrap bits the smaller index is older
function automatic bit ring_older(int a_dir, int a_idx, int b_dir, int b_idx);
    if (a_dir == b_dir) begin
        return a_idx < b_idx;
    end
    return a_idx > b_idx;
endfunction

function automatic bit ref_lq_older(logic [3:0] a, logic [3:0] b);
    return ring_older(a[3], a[2:0], b[3], b[2:0]);
endfunction

// slot index rolls over and flips the wrap bit
function automatic logic [3:0] lq_next(logic [3:0] lq);
    if (lq[2:0] == 3'd7) begin
        return {~lq[3], 3'd0};
    end
    return {lq[3], lq[2:0] + 3'd1};
endfunction

function automatic logic [31:0] ref_addr(logic [31:0] base, logic [11:0] imm);
    return base + {{20{imm[11]}}, imm};
endfunction

function automatic logic [3:0] ref_mask(logic [31:0] addr, logic [1:0] size);
    case (size)
        2'd2: return 4'b1111;
        2'd1: begin
            case (addr[1:0])
                2'd0: return 4'b0011;
                2'd1: return 4'b0110;
                2'd2: return 4'b1100;
                default: return 4'b1000;
            endcase
        end
        default: return 4'b0001 << addr[1:0];
    endcase
endfunction

function automatic bit ref_kill(bit redirect, logic [5:0] redirect_rob, logic [5:0] rob);
    return redirect && ring_older(redirect_rob[5], redirect_rob[4:0], rob[5], rob[4:0]);
endfunction

// load not older than the store, same word, shared byte
function automatic bit ref_hit(bit st_v, logic [31:0] st_addr, logic [3:0] st_mask,
                               logic [3:0] st_lq, bit ld_v, logic [31:0] ld_addr,
                               logic [3:0] ld_mask, logic [3:0] ld_lq);
    return st_v && ld_v && !ref_lq_older(ld_lq, st_lq)
           && (st_addr[31:2] == ld_addr[31:2]) && ((st_mask & ld_mask) != 4'd0);
endfunction

`endif

/* test/lsu_tb.sv */
module lsu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    `include "lsu_ref.svh"

    localparam int RESET_CYC  = 10;
    localparam int N_RANDOM   = 300;
    localparam int N_DIRECTED = 8;
    localparam int PAIR_CYC   = 7;
    localparam int DRAIN_CYC  = 4;
    localparam int TOTAL_CYC  = RESET_CYC + N_RANDOM + N_DIRECTED * PAIR_CYC + DRAIN_CYC;

    typedef struct packed {
        logic        v;
        logic [31:0] base;
        logic [11:0] imm;
        logic [1:0]  size;
        logic [5:0]  rob;
        logic [3:0]  lq;
    } op_t;

    logic               clk = 1'b0;
    logic               rst_i;
    logic               load_valid_i, store_valid_i, redirect_i;
    logic [31:0]        load_base_i, store_base_i;
    logic [11:0]        load_imm_i, store_imm_i;
    lsu_pkg::mem_size_e load_size_i, store_size_i;
    lsu_pkg::rob_idx_t  load_rob_i, store_rob_i, redirect_rob_i;
    logic               load_req_valid_o, load_done_valid_o;
    logic               store_req_valid_o, violation_valid_o;
    logic [31:0]        load_req_addr_o, store_req_addr_o;
    lsu_pkg::mask_t     load_req_mask_o, store_req_mask_o;
    lsu_pkg::rob_idx_t  load_done_rob_o, store_req_rob_o, violation_rob_o;
    lsu_pkg::lq_idx_t   load_done_lq_o;

    // stimulus history indexed by cycle
    op_t        ld_h   [TOTAL_CYC+8];
    op_t        st_h   [TOTAL_CYC+8];
    logic       rd_v   [TOTAL_CYC+8];
    logic [5:0] rd_rob [TOTAL_CYC+8];

    op_t        n_ld, n_st;
    logic       n_rv, n_rst;
    logic [5:0] n_rrob;
    logic [3:0] lq_model;
    logic       prev_rst, prev_ld;
    int         cyc;
    int         errors;
    integer     seed;
    string      test_name;

    always #4 clk = ~clk;

    lsu_top lsu_top_inst (.*);

    task automatic compare_field(input string field, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    function automatic bit killed_at(int c, logic [5:0] rob);
        return ref_kill(rd_v[c], rd_rob[c], rob);
    endfunction

    function automatic logic [31:0] op_addr(op_t op);
        return ref_addr(op.base, op.imm);
    endfunction

    function automatic bit load_hits(op_t st, bit st_ok, op_t ld, bit ld_ok);
        return ref_hit(st_ok, op_addr(st), ref_mask(op_addr(st), st.size), st.lq,
                       ld_ok, op_addr(ld), ref_mask(op_addr(ld), ld.size), ld.lq);
    endfunction

    task automatic clear_stage();
        n_ld   = '0;
        n_st   = '0;
        n_rv   = 1'b0;
        n_rrob = '0;
    endtask

    task automatic apply_cycle();
        @(posedge clk);
        cyc = cyc + 1;
        // next_lq as seen during this cycle
        if (prev_rst) begin
            lq_model = 4'd0;
        end else if (prev_ld) begin
            lq_model = lq_next(lq_model);
        end
        n_ld.lq     = lq_model;
        n_st.lq     = lq_model;
        ld_h[cyc]   = n_ld;
        st_h[cyc]   = n_st;
        // an op issued under reset never enters a pipe
        if (n_rst) begin
            ld_h[cyc].v = 1'b0;
            st_h[cyc].v = 1'b0;
        end
        rd_v[cyc]   = n_rv;
        rd_rob[cyc] = n_rrob;
        prev_rst    = n_rst;
        prev_ld     = n_ld.v;
        rst_i          <= n_rst;
        load_valid_i   <= n_ld.v;
        load_base_i    <= n_ld.base;
        load_imm_i     <= n_ld.imm;
        load_size_i    <= lsu_pkg::mem_size_e'(n_ld.size);
        load_rob_i     <= n_ld.rob;
        store_valid_i  <= n_st.v;
        store_base_i   <= n_st.base;
        store_imm_i    <= n_st.imm;
        store_size_i   <= lsu_pkg::mem_size_e'(n_st.size);
        store_rob_i    <= n_st.rob;
        redirect_i     <= n_rv;
        redirect_rob_i <= n_rrob;
    endtask

    // small address pool so random loads and stores collide
    task automatic random_cycle();
        clear_stage();
        n_ld.v    = ($random(seed) & 3) != 0;
        n_ld.base = 32'h1000 + ($random(seed) & 32'h1c);
        n_ld.imm  = 12'($random(seed) % 8);
        n_ld.size = 2'($unsigned($random(seed)) % 3);
        n_ld.rob  = 6'($random(seed));
        n_st.v    = ($random(seed) & 1) != 0;
        n_st.base = 32'h1000 + ($random(seed) & 32'h1c);
        n_st.imm  = 12'($random(seed) % 8);
        n_st.size = 2'($unsigned($random(seed)) % 3);
        n_st.rob  = 6'($random(seed));
        n_rv      = ($random(seed) & 7) == 0;
        n_rrob    = 6'($random(seed));
        apply_cycle();
    endtask

    // load first, store gap cycles later; the redirect sits between them across the wrap
    task automatic issue_pair(input string name, input int gap, input logic [31:0] ld_addr,
                              input logic [1:0] ld_size, input logic [31:0] st_addr,
                              input logic [1:0] st_size, input bit with_redirect);
        int i;
        test_name = name;
        clear_stage();
        n_ld = '{v: 1'b1, base: ld_addr - 32'd4, imm: 12'd4, size: ld_size, rob: 6'h21, lq: 4'd0};
        for (i = 0; i < gap; i++) begin
            apply_cycle();
            clear_stage();
        end
        n_st   = '{v: 1'b1, base: st_addr + 32'd8, imm: 12'hff8, size: st_size, rob: 6'h1f,
                   lq: 4'd0};
        n_rv   = with_redirect;
        n_rrob = 6'h20;
        apply_cycle();
        clear_stage();
        repeat (4) apply_cycle();
    endtask

    always @(negedge clk) begin : compare_outputs
        op_t        l1, l2, st, vst, vl1, vl2;
        logic       l1_ok, l2_ok, st_ok, vst_ok, vl1_ok, vl2_ok, h1, h2, vio_ok;
        logic [5:0] win_rob;
        if (cyc >= 1 && cyc < 4) begin
            compare_field("load_req_valid", 0, load_req_valid_o);
            compare_field("load_done_valid", 0, load_done_valid_o);
            compare_field("store_req_valid", 0, store_req_valid_o);
            compare_field("violation_valid", 0, violation_valid_o);
        end else if (cyc >= 4) begin
            l1 = ld_h[cyc-1];
            l2 = ld_h[cyc-2];
            st = st_h[cyc-1];
            l1_ok = l1.v && !killed_at(cyc-1, l1.rob);
            compare_field("load_req_valid", l1_ok, load_req_valid_o);
            if (l1_ok) begin
                compare_field("load_req_addr", op_addr(l1), load_req_addr_o);
                compare_field("load_req_mask", ref_mask(op_addr(l1), l1.size), load_req_mask_o);
            end
            l2_ok = l2.v && !killed_at(cyc-2, l2.rob) && !killed_at(cyc-1, l2.rob)
                    && !killed_at(cyc, l2.rob);
            compare_field("load_done_valid", l2_ok, load_done_valid_o);
            if (l2_ok) begin
                compare_field("load_done_rob", l2.rob, load_done_rob_o);
                compare_field("load_done_lq", l2.lq, load_done_lq_o);
            end
            st_ok = st.v && !killed_at(cyc-1, st.rob) && !killed_at(cyc, st.rob);
            compare_field("store_req_valid", st_ok, store_req_valid_o);
            if (st_ok) begin
                compare_field("store_req_addr", op_addr(st), store_req_addr_o);
                compare_field("store_req_mask", ref_mask(op_addr(st), st.size), store_req_mask_o);
                compare_field("store_req_rob", st.rob, store_req_rob_o);
            end
            // detector inputs one cycle back
            vst = st_h[cyc-2];
            vl1 = ld_h[cyc-2];
            vl2 = ld_h[cyc-3];
            vst_ok = vst.v && !killed_at(cyc-2, vst.rob);
            vl1_ok = vl1.v && !killed_at(cyc-2, vl1.rob);
            vl2_ok = vl2.v && !killed_at(cyc-3, vl2.rob) && !killed_at(cyc-2, vl2.rob);
            h1 = load_hits(vst, vst_ok, vl1, vl1_ok);
            h2 = load_hits(vst, vst_ok, vl2, vl2_ok);
            win_rob = (h2 && (!h1 || ref_lq_older(vl2.lq, vl1.lq))) ? vl2.rob : vl1.rob;
            vio_ok = (h1 || h2) && !killed_at(cyc, win_rob);
            compare_field("violation_valid", vio_ok, violation_valid_o);
            if (vio_ok) begin
                compare_field("violation_rob", win_rob, violation_rob_o);
            end
        end
    end

    initial begin : stimulus
        seed           = 32'hc421;
        errors         = 0;
        cyc            = 0;
        lq_model       = 4'd0;
        prev_rst       = 1'b1;
        prev_ld        = 1'b0;
        test_name      = "reset";
        rst_i          = 1'b1;
        load_valid_i   = 1'b0;
        load_base_i    = '0;
        load_imm_i     = '0;
        load_size_i    = lsu_pkg::SIZE_BYTE;
        load_rob_i     = '0;
        store_valid_i  = 1'b0;
        store_base_i   = '0;
        store_imm_i    = '0;
        store_size_i   = lsu_pkg::SIZE_BYTE;
        store_rob_i    = '0;
        redirect_i     = 1'b0;
        redirect_rob_i = '0;
        clear_stage();
        n_rst = 1'b1;
        // live valids under reset, reset must hold every output low
        repeat (RESET_CYC) random_cycle();
        n_rst     = 1'b0;
        test_name = "random";
        repeat (N_RANDOM) random_cycle();
        issue_pair("vio_word", 0, 32'h2000, lsu_pkg::SIZE_WORD, 32'h2000, lsu_pkg::SIZE_WORD, 0);
        issue_pair("vio_half", 0, 32'h2002, lsu_pkg::SIZE_HALF, 32'h2003, lsu_pkg::SIZE_BYTE, 0);
        issue_pair("older_gap1", 1, 32'h2004, lsu_pkg::SIZE_WORD, 32'h2004, lsu_pkg::SIZE_BYTE, 0);
        issue_pair("older_gap2", 2, 32'h2008, lsu_pkg::SIZE_BYTE, 32'h2008, lsu_pkg::SIZE_WORD, 0);
        issue_pair("disjoint_mask", 0, 32'h2010, lsu_pkg::SIZE_HALF, 32'h2012,
                   lsu_pkg::SIZE_HALF, 0);
        issue_pair("other_word", 0, 32'h2020, lsu_pkg::SIZE_WORD, 32'h2024, lsu_pkg::SIZE_WORD, 0);
        issue_pair("redirect_wrap", 0, 32'h2030, lsu_pkg::SIZE_WORD, 32'h2030,
                   lsu_pkg::SIZE_WORD, 1);
        issue_pair("redirect_s1", 1, 32'h2040, lsu_pkg::SIZE_WORD, 32'h2040,
                   lsu_pkg::SIZE_WORD, 1);
        test_name = "drain";
        clear_stage();
        repeat (DRAIN_CYC) apply_cycle();
        @(negedge clk);
        #1;
        $display("checked %0d cycles, errors: %0d", cyc, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #((TOTAL_CYC + 50) * 8);
        $display("timeout: run still active after %0d cycles", TOTAL_CYC + 50);
        $display("Errors found");
        $finish;
    end

endmodule
